// ==== i2c_pkg.sv ====
// Shared types and constants for the EEPROM I2C master.
// dri_clk is one quarter of an SCL period, so bus speed is set by dri_clk.
// One fixed 7-bit device address; word addresses are 8 or 16 bits.
`default_nettype none

package i2c_pkg;

    //********************
    // bus constants
    //********************
    localparam logic [6:0] DEV_ADDR     = 7'b1010000;  // eeprom slave address
    localparam int         BIT_QUARTERS = 4;           // dri_clk cycles per scl bit
    localparam int         QTR_W        = $clog2(BIT_QUARTERS);

    //********************
    // word address
    //********************
    typedef struct packed {
        logic [7:0] hi;                 // sent first in 16-bit mode
        logic [7:0] lo;
    } addr_bytes_t;

    // one address word, or the two bytes that go on the bus
    typedef union packed {
        logic [15:0] word;
        addr_bytes_t bytes;
    } addr_u;

    //********************
    // user handshake
    //********************
    typedef struct packed {
        logic       rd;                 // 1: random read, 0: byte write
        logic       addr16;             // 1: two address bytes
        addr_u      addr;
        logic [7:0] wdata;
    } i2c_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;               // any slave nack in the transaction
    } i2c_rsp_t;

    //********************
    // fsm to engine
    //********************
    typedef enum logic [2:0] {
        FR_START_BYTE   = 3'd0,         // start, then a byte
        FR_RESTART_BYTE = 3'd1,         // repeated start, then a byte
        FR_TX_BYTE      = 3'd2,
        FR_RX_BYTE      = 3'd3,         // read a byte, master nack
        FR_STOP         = 3'd4
    } frame_kind_e;

    typedef struct packed {
        frame_kind_e kind;
        logic [7:0]  tx_byte;           // ignored for rx and stop
    } frame_cmd_t;

endpackage

`default_nettype wire

// ==== i2c_bit_engine.sv ====
// Runs one framed byte on SCL/SDA, one dri_clk cycle per SCL quarter.
// frame_go is only honoured while idle; the FSM keeps one frame in flight.
// Lengths from frame_go to frame_done: start/restart 39, tx/rx 35, stop 16.
`default_nettype none

module i2c_bit_engine (
    input  logic                dri_clk,
    input  logic                rst_n,
    input  logic                frame_go,
    input  i2c_pkg::frame_cmd_t frame,
    input  logic                sda_in,
    output logic                frame_done,
    output logic                ack_n,
    output logic [7:0]          rx_byte,
    output logic                scl,
    output logic                sda_out,
    output logic                sda_oe
);

    logic                      busy;
    i2c_pkg::frame_kind_e      kind_q;
    logic                      pre;        // in start/restart prefix
    logic [3:0]                bit_idx;    // 0..7 data, 8 ack
    logic [i2c_pkg::QTR_W-1:0] qtr;
    logic [7:0]                tx_q;

    logic                      act;
    i2c_pkg::frame_kind_e      kind_c;
    logic                      pre_c;
    logic [3:0]                bi_c;
    logic [i2c_pkg::QTR_W-1:0] qc;
    logic [7:0]                byte_c;
    logic                      last_q;
    logic                      ack_bit;
    logic [3:0]                stop_step;
    logic                      rx_shift;

    //********************
    // current position
    //********************
    // the first quarter runs on the edge that takes frame_go
    assign act     = busy | frame_go;
    assign kind_c  = busy ? kind_q : frame.kind;
    assign pre_c   = busy ? pre : (frame.kind == i2c_pkg::FR_START_BYTE ||
                                   frame.kind == i2c_pkg::FR_RESTART_BYTE);
    assign bi_c    = busy ? bit_idx : 4'd0;
    assign qc      = busy ? qtr : '0;
    assign byte_c  = busy ? tx_q : frame.tx_byte;

    assign last_q    = (int'(qc) == i2c_pkg::BIT_QUARTERS - 1);
    assign ack_bit   = (bi_c == 4'd8);
    assign stop_step = {bi_c[1:0], qc};                 // 16 quarters of stop
    assign rx_shift  = act && !pre_c && !ack_bit && (qc == 2) &&
                       (kind_c == i2c_pkg::FR_RX_BYTE);

    //********************
    // quarter sequencer
    //********************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            kind_q     <= i2c_pkg::FR_STOP;
            pre        <= 1'b0;
            bit_idx    <= 4'd0;
            qtr        <= '0;
            scl        <= 1'b1;
            sda_out    <= 1'b1;
            sda_oe     <= 1'b0;
            frame_done <= 1'b0;
            ack_n      <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (act) begin
                busy    <= 1'b1;
                kind_q  <= kind_c;
                qtr     <= qc + 1'b1;
                pre     <= pre_c && !last_q;
                bit_idx <= (last_q && !pre_c) ? bi_c + 4'd1 : bi_c;
                if (kind_c == i2c_pkg::FR_STOP) begin
                    case (stop_step)
                        4'd0: begin
                            sda_oe  <= 1'b1;            // sda low while scl low
                            sda_out <= 1'b0;
                        end
                        4'd1: scl <= 1'b1;
                        4'd3: sda_oe <= 1'b0;           // sda rises, stop
                        4'd15: begin
                            frame_done <= 1'b1;         // bus free time elapsed
                            ack_n      <= 1'b0;
                            busy       <= 1'b0;
                        end
                        default: ;
                    endcase
                end else if (pre_c) begin
                    case (qc)
                        0: begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b1;
                        end
                        1: scl <= 1'b1;
                        2: sda_out <= 1'b0;             // start edge, scl high
                        3: scl <= 1'b0;
                        default: ;
                    endcase
                end else begin
                    case (qc)
                        0: begin
                            if (ack_bit) begin
                                sda_oe  <= (kind_c == i2c_pkg::FR_RX_BYTE);  // master nack
                                sda_out <= 1'b1;
                            end else if (kind_c == i2c_pkg::FR_RX_BYTE) begin
                                sda_oe <= 1'b0;         // slave drives data
                            end else begin
                                sda_oe  <= 1'b1;
                                sda_out <= byte_c[3'd7 - bi_c[2:0]];    // msb first
                            end
                        end
                        1: scl <= 1'b1;
                        2: begin
                            if (ack_bit) begin
                                ack_n      <= sda_in;
                                frame_done <= 1'b1;
                            end
                        end
                        3: begin
                            scl <= 1'b0;
                            if (ack_bit) begin
                                busy <= 1'b0;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // data path
    always_ff @(posedge dri_clk) begin
        if (frame_go && !busy) begin
            tx_q <= frame.tx_byte;
        end
        if (rx_shift) begin
            rx_byte <= {rx_byte[6:0], sda_in};
        end
    end

endmodule

`default_nettype wire

// ==== i2c_txn_fsm.sv ====
// Transaction FSM for one EEPROM byte write or random byte read.
// i2c_exec is taken only in idle; a pulse while busy is dropped.
// A slave nack does not abort, the transaction still ends with a stop.
`default_nettype none

module i2c_txn_fsm (
    input  logic                dri_clk,
    input  logic                rst_n,
    input  logic                i2c_exec,
    input  i2c_pkg::i2c_req_t   req,
    input  logic                frame_done,
    input  logic                ack_n,
    input  logic [7:0]          rx_byte,
    output logic                frame_go,
    output i2c_pkg::frame_cmd_t frame,
    output logic                i2c_done,
    output i2c_pkg::i2c_rsp_t   rsp
);

    // state names the frame in flight
    typedef enum logic [2:0] {
        st_idle,
        st_dev_wr,
        st_addr_hi,
        st_addr_lo,
        st_data_wr,
        st_dev_rd,
        st_data_rd,
        st_stop
    } state_e;

    state_e              state;
    state_e              state_nxt;
    i2c_pkg::i2c_req_t   req_q;
    i2c_pkg::frame_cmd_t cmd_nxt;
    logic                advance;

    assign advance = (state == st_idle) ? i2c_exec : frame_done;

    //********************
    // next frame
    //********************
    always_comb begin
        state_nxt       = state;
        cmd_nxt.kind    = i2c_pkg::FR_TX_BYTE;
        cmd_nxt.tx_byte = 8'h00;
        case (state)
            st_idle: begin
                state_nxt       = st_dev_wr;
                cmd_nxt.kind    = i2c_pkg::FR_START_BYTE;
                cmd_nxt.tx_byte = {i2c_pkg::DEV_ADDR, 1'b0};    // write
            end
            st_dev_wr: begin
                if (req_q.addr16) begin
                    state_nxt       = st_addr_hi;
                    cmd_nxt.tx_byte = req_q.addr.bytes.hi;
                end else begin
                    state_nxt       = st_addr_lo;
                    cmd_nxt.tx_byte = req_q.addr.bytes.lo;
                end
            end
            st_addr_hi: begin
                state_nxt       = st_addr_lo;
                cmd_nxt.tx_byte = req_q.addr.bytes.lo;
            end
            st_addr_lo: begin
                if (req_q.rd) begin
                    state_nxt       = st_dev_rd;
                    cmd_nxt.kind    = i2c_pkg::FR_RESTART_BYTE;
                    cmd_nxt.tx_byte = {i2c_pkg::DEV_ADDR, 1'b1};    // read
                end else begin
                    state_nxt       = st_data_wr;
                    cmd_nxt.tx_byte = req_q.wdata;
                end
            end
            st_dev_rd: begin
                state_nxt    = st_data_rd;
                cmd_nxt.kind = i2c_pkg::FR_RX_BYTE;
            end
            st_data_wr,
            st_data_rd: begin
                state_nxt    = st_stop;
                cmd_nxt.kind = i2c_pkg::FR_STOP;
            end
            default: state_nxt = st_idle;                   // stop finished
        endcase
    end

    //********************
    // state and response
    //********************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            frame_go <= 1'b0;
            frame    <= '0;
            i2c_done <= 1'b0;
            rsp      <= '0;
        end else begin
            frame_go <= 1'b0;
            i2c_done <= 1'b0;
            if (advance) begin
                state    <= state_nxt;
                frame    <= cmd_nxt;
                frame_go <= (state != st_stop);
                i2c_done <= (state == st_stop);
            end
            if (state == st_idle && i2c_exec) begin
                rsp.nack <= 1'b0;                           // new transaction
            end else if (frame_done && state != st_data_rd) begin
                rsp.nack <= rsp.nack | ack_n;
            end
            if (frame_done && state == st_data_rd) begin
                rsp.rdata <= rx_byte;
            end
        end
    end

    // request held for the whole transaction
    always_ff @(posedge dri_clk) begin
        if (state == st_idle && i2c_exec) begin
            req_q <= req;
        end
    end

endmodule

`default_nettype wire

// ==== i2c_master.sv ====
// I2C master for a serial EEPROM, byte write and random byte read.
// dri_clk is four times the SCL rate; sda needs a pull-up on the board.
// scl is push-pull, so no clock stretching by the slave.
`default_nettype none

module i2c_master (
    input  logic              dri_clk,
    input  logic              rst_n,
    input  logic              i2c_exec,
    input  i2c_pkg::i2c_req_t req,
    output logic              i2c_done,
    output i2c_pkg::i2c_rsp_t rsp,
    output logic              scl,
    inout  wire               sda
);

    logic                frame_go;
    i2c_pkg::frame_cmd_t frame;
    logic                frame_done;
    logic                ack_n;
    logic [7:0]          rx_byte;
    logic                sda_out;
    logic                sda_oe;
    logic                sda_in;

    //********************
    // sda pad
    //********************
    assign sda    = sda_oe ? sda_out : 1'bz;    // released to pull-up
    assign sda_in = sda;

    i2c_txn_fsm u_txn_fsm (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .i2c_exec   (i2c_exec),
        .req        (req),
        .frame_done (frame_done),
        .ack_n      (ack_n),
        .rx_byte    (rx_byte),
        .frame_go   (frame_go),
        .frame      (frame),
        .i2c_done   (i2c_done),
        .rsp        (rsp)
    );

    i2c_bit_engine u_bit_engine (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .frame_go   (frame_go),
        .frame      (frame),
        .sda_in     (sda_in),
        .frame_done (frame_done),
        .ack_n      (ack_n),
        .rx_byte    (rx_byte),
        .scl        (scl),
        .sda_out    (sda_out),
        .sda_oe     (sda_oe)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// Testbench clock and reset: 10 ns dri_clk, rst_n low for 4 cycles.
`default_nettype none

module tb_clk_gen (
    output logic dri_clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        dri_clk = 1'b0;
        forever #5 dri_clk = ~dri_clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge dri_clk);
        rst_n <= 1'b1;                  // released on a clock edge
    end

endmodule

`default_nettype wire

// ==== i2c_eeprom_model.sv ====
// Behavioral EEPROM slave, 64K bytes, single-byte write and read only.
// Word address width is taken from the byte count (1 byte maps to 0x00xx).
// force_nack makes the slave NACK every byte; nothing is then written.
// The slave moves SDA 15 ns after SCL falls, while SCL is still low.
`default_nettype none

module i2c_eeprom_model (
    input  wire  scl,
    inout  wire  sda,
    input  logic force_nack
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [0:65535];
    logic [7:0]  abuf [0:2];
    logic [7:0]  shreg;
    logic [7:0]  dout;
    logic [15:0] ptr;
    logic        drive_low;
    logic        nxt_low;
    logic        active;
    logic        got_dev;
    logic        sel;
    logic        rd_mode;
    logic        in_ack;
    logic        sending;
    logic        nacked;
    int          bit_cnt;
    int          byte_cnt;

    assign sda = drive_low ? 1'b0 : 1'bz;       // open drain

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = i[15:8] ^ {i[6:0], i[7]} ^ 8'hc3;     // whole-address fill
        end
        drive_low = 1'b0;
        active    = 1'b0;
        ptr       = '0;
    end

    //********************
    // start and stop
    //********************
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            if (byte_cnt == 1) begin
                ptr = {8'h00, abuf[0]};         // address set by dummy write
            end else if (byte_cnt == 2) begin
                ptr = {abuf[0], abuf[1]};
            end
            active   = 1'b1;
            got_dev  = 1'b0;
            sel      = 1'b0;
            rd_mode  = 1'b0;
            in_ack   = 1'b0;
            sending  = 1'b0;
            nacked   = 1'b0;
            bit_cnt  = 0;
            byte_cnt = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1 && active) begin
            if (sel && !rd_mode && !nacked && byte_cnt == 2) begin
                mem[{8'h00, abuf[0]}] = abuf[1];
            end else if (sel && !rd_mode && !nacked && byte_cnt == 3) begin
                mem[{abuf[0], abuf[1]}] = abuf[2];
            end
            active   = 1'b0;
            byte_cnt = 0;
        end
    end

    //********************
    // bit level
    //********************
    always @(posedge scl) begin
        if (active && !in_ack) begin
            shreg   = {shreg[6:0], sda};
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl) begin
        if (active) begin
            drive_low = 1'b0;
            nxt_low   = 1'b0;
            if (in_ack) begin
                in_ack = 1'b0;
                if (sending) begin
                    sending = 1'b0;             // one byte per read
                end else if (rd_mode && sel) begin
                    sending = 1'b1;
                    dout    = mem[ptr];
                    ptr     = ptr + 16'd1;
                    nxt_low = !dout[7];
                end
            end else if (bit_cnt == 8) begin
                bit_cnt = 0;
                in_ack  = 1'b1;
                if (!sending) begin
                    if (!got_dev) begin
                        got_dev = 1'b1;
                        sel     = (shreg[7:1] == i2c_pkg::DEV_ADDR) && !force_nack;
                        rd_mode = shreg[0];
                        nxt_low = sel;
                    end else begin
                        if (byte_cnt < 3) begin
                            abuf[byte_cnt] = shreg;
                        end
                        byte_cnt = byte_cnt + 1;
                        nacked   = nacked | force_nack;
                        nxt_low  = sel && !force_nack;
                    end
                end
            end else if (sending) begin
                nxt_low = !dout[7 - bit_cnt];
            end
            #15;
            drive_low = nxt_low;
        end
    end

endmodule

`default_nettype wire

// ==== i2c_master_chk.sv ====
// Bus protocol assertions, bound into every i2c_master instance.
// Idle spans from i2c_done (or reset) to the next i2c_exec.
`default_nettype none

module i2c_master_chk (
    input logic dri_clk,
    input logic rst_n,
    input logic i2c_exec,
    input logic i2c_done,
    input logic scl,
    input wire  sda,
    input logic sda_oe
);
    timeunit 1ns;
    timeprecision 100ps;

    logic idle;
    int   assert_fails = 0;

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            idle <= 1'b1;
        end else if (idle && i2c_exec) begin
            idle <= 1'b0;
        end else if (i2c_done) begin
            idle <= 1'b1;
        end
    end

    // fall with master driving is a start, rise on release is a stop
    a_sda_stable: assert property (@(posedge dri_clk) disable iff (!rst_n)
        (scl && $past(scl) && $changed(sda)) |->
            ((sda_oe && $fell(sda)) || (!sda_oe && $rose(sda))))
        else begin
            $error("sda moved while scl high outside start or stop");
            assert_fails++;
        end

    a_done_pulse: assert property (@(posedge dri_clk) disable iff (!rst_n)
        i2c_done |=> !i2c_done)
        else begin
            $error("i2c_done longer than one cycle");
            assert_fails++;
        end

    a_idle_scl: assert property (@(posedge dri_clk) disable iff (!rst_n)
        idle |-> scl)
        else begin
            $error("scl low while idle");
            assert_fails++;
        end

    a_scl_high: assert property (@(posedge dri_clk) disable iff (!rst_n)
        $rose(scl) |-> scl [*i2c_pkg::BIT_QUARTERS/2])
        else begin
            $error("scl high phase too short");
            assert_fails++;
        end

endmodule

bind i2c_master i2c_master_chk u_chk (
    .dri_clk  (dri_clk),
    .rst_n    (rst_n),
    .i2c_exec (i2c_exec),
    .i2c_done (i2c_done),
    .scl      (scl),
    .sda      (sda),
    .sda_oe   (sda_oe)
);

`default_nettype wire

// ==== tb_i2c_master.sv ====
// Random write/read testbench for i2c_master against a behavioral EEPROM.
// Expected bytes come from a reference memory with the same fill rule.
// An 8-bit word address maps to 0x00xx in the 64K space.
`default_nettype none

module tb_i2c_master;
    timeunit 1ns;
    timeprecision 100ps;

    logic              dri_clk;
    logic              rst_n;
    logic              i2c_exec;
    i2c_pkg::i2c_req_t req;
    logic              i2c_done;
    i2c_pkg::i2c_rsp_t rsp;
    logic              scl;
    logic              force_nack;
    wire               sda;

    integer     seed = 32'hdbbfe032;
    int         errors = 0;
    int         checks = 0;
    logic       timed_out = 1'b0;
    logic [7:0] ref_mem [int];

    pullup (sda);

    tb_clk_gen u_clk_gen (.dri_clk(dri_clk), .rst_n(rst_n));

    i2c_master i2c_master_i (
        .dri_clk  (dri_clk),
        .rst_n    (rst_n),
        .i2c_exec (i2c_exec),
        .req      (req),
        .i2c_done (i2c_done),
        .rsp      (rsp),
        .scl      (scl),
        .sda      (sda)
    );

    i2c_eeprom_model u_eeprom (.scl(scl), .sda(sda), .force_nack(force_nack));

    //********************
    // reference model
    //********************
    function automatic int mem_index(input logic a16, input logic [15:0] addr);
        return a16 ? int'(addr) : int'({8'h00, addr[7:0]});
    endfunction

    function automatic logic [7:0] expected_byte(input int idx);
        logic [15:0] a;
        a = idx[15:0];
        if (ref_mem.exists(idx)) begin
            return ref_mem[idx];
        end
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'hc3;        // untouched cell
    endfunction

    task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("Mismatch %s expected %h actual %h at %0t", name, exp, act, $time);
        end
    endtask

    task automatic run_txn(input logic rd, input logic a16, input logic [15:0] addr,
                           input logic [7:0] wdata);
        int cnt;
        cnt = 0;
        if (!timed_out) begin
            @(posedge dri_clk);
            req.rd        <= rd;
            req.addr16    <= a16;
            req.addr.word <= addr;
            req.wdata     <= wdata;
            i2c_exec      <= 1'b1;
            @(posedge dri_clk);
            i2c_exec <= 1'b0;
            while (i2c_done !== 1'b1 && !timed_out) begin
                @(posedge dri_clk);
                cnt++;
                if (cnt > 2000) begin
                    timed_out = 1'b1;
                    $display("Timeout: i2c_done not seen within 2000 cycles at %0t", $time);
                end
            end
        end
    endtask

    task automatic write_check(input logic a16, input logic [15:0] addr, input logic [7:0] d);
        run_txn(1'b0, a16, addr, d);
        compare("rsp.nack", 8'h00, {7'd0, rsp.nack});
        ref_mem[mem_index(a16, addr)] = d;
    endtask

    task automatic read_check(input logic a16, input logic [15:0] addr);
        run_txn(1'b1, a16, addr, 8'h00);
        compare("rsp.nack", 8'h00, {7'd0, rsp.nack});
        compare("rsp.rdata", expected_byte(mem_index(a16, addr)), rsp.rdata);
    endtask

    //********************
    // test sequence
    //********************
    initial begin
        logic [15:0] addr;
        logic [7:0]  hi2;
        logic [7:0]  d;
        int          cnt;
        i2c_exec   = 1'b0;
        req        = '0;
        force_nack = 1'b0;
        cnt        = 0;
        while (rst_n !== 1'b1 && !timed_out) begin
            @(posedge dri_clk);
            cnt++;
            if (cnt > 100) begin
                timed_out = 1'b1;
                $display("Timeout: reset never released");
            end
        end

        // idle bus after reset
        repeat (20) begin
            @(posedge dri_clk);
            compare("scl", 8'h01, {7'd0, scl});
            compare("sda", 8'h01, {7'd0, sda});
            compare("i2c_done", 8'h00, {7'd0, i2c_done});
        end

        // 8-bit address write then read
        repeat (20) begin
            addr = $random(seed);
            d    = $random(seed);
            write_check(1'b0, {8'h00, addr[7:0]}, d);
            read_check(1'b0, {8'h00, addr[7:0]});
        end

        // 16-bit, two addresses differing only in the high byte
        repeat (20) begin
            addr = $random(seed);
            hi2  = addr[15:8] ^ (8'h01 << ($unsigned($random(seed)) % 8));
            write_check(1'b1, addr, $random(seed));
            write_check(1'b1, {hi2, addr[7:0]}, $random(seed));
            read_check(1'b1, addr);
            read_check(1'b1, {hi2, addr[7:0]});
        end

        // forced NACK leaves memory untouched
        addr = $random(seed);
        force_nack <= 1'b1;
        run_txn(1'b0, 1'b1, addr, ~expected_byte(mem_index(1'b1, addr)));
        compare("rsp.nack", 8'h01, {7'd0, rsp.nack});
        force_nack <= 1'b0;
        read_check(1'b1, addr);

        // mixed random traffic
        repeat (200) begin
            addr = $random(seed);
            d    = $random(seed);
            if (d[0]) begin
                read_check(addr[0], addr);
            end else begin
                write_check(addr[0], addr, $random(seed));
            end
        end

        repeat (10) @(posedge dri_clk);
        $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timed_out, i2c_master_i.u_chk.assert_fails);
        if (errors == 0 && !timed_out && i2c_master_i.u_chk.assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
i2c_pkg.sv
i2c_bit_engine.sv
i2c_txn_fsm.sv
i2c_master.sv
tb_clk_gen.sv
i2c_eeprom_model.sv
i2c_master_chk.sv
tb_i2c_master.sv
